//--- src/nms_pkg.sv
// Image geometry, pixel and gradient sum types, FIFO depth

package nms_pkg;

    // Gradient magnitude of one pixel
    typedef logic [7:0] pixel_t;

    // Sum of two opposite neighbours, one bit wider than a pixel
    typedef logic [8:0] grad_sum_t;

    // Frame size in pixels
    localparam int IMG_WIDTH = 16;
    localparam int IMG_HEIGHT = 12;
    localparam int PIXEL_COUNT = IMG_WIDTH * IMG_HEIGHT;

    // Two full rows plus three pixels hold one 3x3 neighbourhood
    localparam int WINDOW_LEN = 2 * IMG_WIDTH + 3;

    // Depth of both pixel FIFOs, must be a power of two
    localparam int FIFO_DEPTH = 16;

endpackage

//--- src/pixel_fifo.sv
// Synchronous first-word-fall-through pixel FIFO with full and empty flags
`timescale 1ns/1ns

module pixel_fifo #(
    parameter int DEPTH = nms_pkg::FIFO_DEPTH
) (
    input  logic            clock,
    input  logic            reset,
    input  logic            wr_en,
    input  nms_pkg::pixel_t din,
    output logic            full,
    input  logic            rd_en,
    output nms_pkg::pixel_t dout,
    output logic            empty
);

    import nms_pkg::*;

    pixel_t mem [DEPTH];

    // Pointers carry one extra wrap bit to tell full from empty
    logic [$clog2(DEPTH):0] wr_ptr;
    logic [$clog2(DEPTH):0] rd_ptr;
    logic                   do_write;
    logic                   do_read;

    // Writes when full and reads when empty are ignored
    assign do_write = wr_en && !full;
    assign do_read = rd_en && !empty;

    assign empty = (wr_ptr == rd_ptr);
    assign full = (wr_ptr[$clog2(DEPTH)] != rd_ptr[$clog2(DEPTH)]) &&
                  (wr_ptr[$clog2(DEPTH)-1:0] == rd_ptr[$clog2(DEPTH)-1:0]);

    // Head word is always presented
    assign dout = mem[rd_ptr[$clog2(DEPTH)-1:0]];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (do_write) begin
            mem[wr_ptr[$clog2(DEPTH)-1:0]] <= din;
        end
    end

endmodule

//--- src/line_window.sv
// Line buffer shift register that builds 3x3 windows with row and column tracking
`timescale 1ns/1ns

module line_window (
    input  logic            clock,
    input  logic            reset,
    output logic            rd_en,
    input  nms_pkg::pixel_t dout,
    input  logic            empty,
    output nms_pkg::pixel_t p_nw,
    output nms_pkg::pixel_t p_n,
    output nms_pkg::pixel_t p_ne,
    output nms_pkg::pixel_t p_w,
    output nms_pkg::pixel_t p_c,
    output nms_pkg::pixel_t p_e,
    output nms_pkg::pixel_t p_sw,
    output nms_pkg::pixel_t p_s,
    output nms_pkg::pixel_t p_se,
    output logic            border,
    output logic            window_valid,
    input  logic            window_take
);

    import nms_pkg::*;

    typedef enum logic {PROLOGUE, STREAM} state_t;
    typedef logic [$clog2(IMG_WIDTH+2)-1:0] fill_t;
    typedef logic [$clog2(IMG_WIDTH)-1:0] col_t;
    typedef logic [$clog2(IMG_HEIGHT)-1:0] row_t;

    state_t state;
    pixel_t shift_reg [WINDOW_LEN];
    fill_t  fill_cnt;
    col_t   col;
    row_t   row;
    logic   pad;
    logic   last_pos;
    logic   shift_en;
    pixel_t shift_in;

    // No input pixel is left for the last windows of a frame
    assign pad = (row == row_t'(IMG_HEIGHT - 1)) ||
                 ((row == row_t'(IMG_HEIGHT - 2)) && (col >= col_t'(IMG_WIDTH - 2)));
    assign last_pos = (row == row_t'(IMG_HEIGHT - 1)) && (col == col_t'(IMG_WIDTH - 1));

    assign rd_en = (state == PROLOGUE) ? !empty : (window_take && !pad);
    // Last window of a frame needs no shift
    assign shift_en = rd_en || (window_take && pad && !last_pos);
    assign shift_in = rd_en ? dout : '0;

    assign window_valid = (state == STREAM) && (pad || !empty);
    assign border = (row == '0) || (row == row_t'(IMG_HEIGHT - 1)) ||
                    (col == '0) || (col == col_t'(IMG_WIDTH - 1));

    // Oldest pixel sits at index 0, the centre at IMG_WIDTH+1
    assign p_nw = shift_reg[0];
    assign p_n  = shift_reg[1];
    assign p_ne = shift_reg[2];
    assign p_w  = shift_reg[IMG_WIDTH];
    assign p_c  = shift_reg[IMG_WIDTH + 1];
    assign p_e  = shift_reg[IMG_WIDTH + 2];
    assign p_sw = shift_reg[2 * IMG_WIDTH];
    assign p_s  = shift_reg[2 * IMG_WIDTH + 1];
    assign p_se = shift_reg[2 * IMG_WIDTH + 2];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= PROLOGUE;
            fill_cnt <= '0;
            row <= '0;
            col <= '0;
        end else if (state == PROLOGUE) begin
            // Fill until the centre reaches the first pixel of the frame
            if (!empty) begin
                if (fill_cnt == fill_t'(IMG_WIDTH + 1)) begin
                    fill_cnt <= '0;
                    state <= STREAM;
                end else begin
                    fill_cnt <= fill_cnt + 1'b1;
                end
            end
        end else if (window_take) begin
            if (last_pos) begin
                state <= PROLOGUE;
                row <= '0;
                col <= '0;
            end else if (col == col_t'(IMG_WIDTH - 1)) begin
                col <= '0;
                row <= row + 1'b1;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (shift_en) begin
            for (int i = 0; i < WINDOW_LEN - 1; i++) begin
                shift_reg[i] <= shift_reg[i + 1];
            end
            shift_reg[WINDOW_LEN - 1] <= shift_in;
        end
    end

endmodule

//--- src/nms_suppress.sv
// Direction choice, local maximum test and result register for the output FIFO
`timescale 1ns/1ns

module nms_suppress (
    input  logic            clock,
    input  logic            reset,
    input  nms_pkg::pixel_t p_nw,
    input  nms_pkg::pixel_t p_n,
    input  nms_pkg::pixel_t p_ne,
    input  nms_pkg::pixel_t p_w,
    input  nms_pkg::pixel_t p_c,
    input  nms_pkg::pixel_t p_e,
    input  nms_pkg::pixel_t p_sw,
    input  nms_pkg::pixel_t p_s,
    input  nms_pkg::pixel_t p_se,
    input  logic            border,
    input  logic            window_valid,
    output logic            window_take,
    output logic            wr_en,
    output nms_pkg::pixel_t din,
    input  logic            full
);

    import nms_pkg::*;

    grad_sum_t ns_sum;
    grad_sum_t we_sum;
    grad_sum_t nwse_sum;
    grad_sum_t nesw_sum;
    pixel_t    result;
    pixel_t    res_data;
    logic      res_valid;

    assign ns_sum = grad_sum_t'(p_n) + grad_sum_t'(p_s);
    assign we_sum = grad_sum_t'(p_w) + grad_sum_t'(p_e);
    assign nwse_sum = grad_sum_t'(p_nw) + grad_sum_t'(p_se);
    assign nesw_sum = grad_sum_t'(p_ne) + grad_sum_t'(p_sw);

    // Ties go to the earlier direction in N-S, W-E, NW, NE order
    always_comb begin
        result = '0;
        if (!border) begin
            if (ns_sum >= we_sum && ns_sum >= nwse_sum && ns_sum >= nesw_sum) begin
                if (p_c > p_w && p_c >= p_e) begin
                    result = p_c;
                end
            end else if (we_sum >= nwse_sum && we_sum >= nesw_sum) begin
                if (p_c > p_n && p_c >= p_s) begin
                    result = p_c;
                end
            end else if (nwse_sum >= nesw_sum) begin
                if (p_c > p_ne && p_c >= p_sw) begin
                    result = p_c;
                end
            end else begin
                if (p_c > p_nw && p_c >= p_se) begin
                    result = p_c;
                end
            end
        end
    end

    // Take when the result register is free or being written this cycle
    assign window_take = window_valid && (!res_valid || !full);
    assign wr_en = res_valid;
    assign din = res_data;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            res_valid <= 1'b0;
        end else if (window_take) begin
            res_valid <= 1'b1;
        end else if (!full) begin
            res_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (window_take) begin
            res_data <= result;
        end
    end

endmodule

//--- src/nms_top.sv
// Input FIFO, window builder, suppression stage and output FIFO
`timescale 1ns/1ns

module nms_top (
    input  logic            clock,
    input  logic            reset,
    input  logic            in_wr_en,
    input  nms_pkg::pixel_t in_din,
    output logic            in_full,
    input  logic            out_rd_en,
    output nms_pkg::pixel_t out_dout,
    output logic            out_empty
);

    import nms_pkg::*;

    logic   win_rd_en;
    pixel_t fifo_dout;
    logic   fifo_empty;

    // Window between builder and decision stage
    pixel_t p_nw, p_n, p_ne;
    pixel_t p_w, p_c, p_e;
    pixel_t p_sw, p_s, p_se;
    logic   border;
    logic   window_valid;
    logic   window_take;

    logic   res_wr_en;
    pixel_t res_din;
    logic   res_full;

    pixel_fifo #(.DEPTH(FIFO_DEPTH)) in_fifo_i (
        .clock (clock),
        .reset (reset),
        .wr_en (in_wr_en),
        .din   (in_din),
        .full  (in_full),
        .rd_en (win_rd_en),
        .dout  (fifo_dout),
        .empty (fifo_empty)
    );

    line_window line_window_i (
        .clock        (clock),
        .reset        (reset),
        .rd_en        (win_rd_en),
        .dout         (fifo_dout),
        .empty        (fifo_empty),
        .p_nw         (p_nw),
        .p_n          (p_n),
        .p_ne         (p_ne),
        .p_w          (p_w),
        .p_c          (p_c),
        .p_e          (p_e),
        .p_sw         (p_sw),
        .p_s          (p_s),
        .p_se         (p_se),
        .border       (border),
        .window_valid (window_valid),
        .window_take  (window_take)
    );

    nms_suppress nms_suppress_i (
        .clock        (clock),
        .reset        (reset),
        .p_nw         (p_nw),
        .p_n          (p_n),
        .p_ne         (p_ne),
        .p_w          (p_w),
        .p_c          (p_c),
        .p_e          (p_e),
        .p_sw         (p_sw),
        .p_s          (p_s),
        .p_se         (p_se),
        .border       (border),
        .window_valid (window_valid),
        .window_take  (window_take),
        .wr_en        (res_wr_en),
        .din          (res_din),
        .full         (res_full)
    );

    pixel_fifo #(.DEPTH(FIFO_DEPTH)) out_fifo_i (
        .clock (clock),
        .reset (reset),
        .wr_en (res_wr_en),
        .din   (res_din),
        .full  (res_full),
        .rd_en (out_rd_en),
        .dout  (out_dout),
        .empty (out_empty)
    );

endmodule

//--- verification/nms_assert.sv
// Concurrent checks on the FIFO flags and the window handshake, bound into nms_top
`timescale 1ns/1ns

module nms_assert (
    input logic            clock,
    input logic            reset,
    input logic            in_wr_en,
    input logic            fifo_empty,
    input logic            res_wr_en,
    input logic            out_empty,
    input nms_pkg::pixel_t p_c,
    input logic            border,
    input logic            window_valid,
    input logic            window_take
);

    // A write into an empty FIFO is presented at the next edge
    in_fifo_empty_falls: assert property (@(posedge clock) disable iff (reset)
        (in_wr_en && fifo_empty) |=> !fifo_empty)
        else $error("input FIFO still empty one cycle after a write");

    out_fifo_empty_falls: assert property (@(posedge clock) disable iff (reset)
        (res_wr_en && out_empty) |=> !out_empty)
        else $error("output FIFO still empty one cycle after a write");

    // An offered window stays offered until taken
    valid_held: assert property (@(posedge clock) disable iff (reset)
        (window_valid && !window_take) |=> window_valid)
        else $error("window_valid dropped before the window was taken");

    // No shift and no counter step while a window waits
    window_held: assert property (@(posedge clock) disable iff (reset)
        (window_valid && !window_take) |=> ($stable(p_c) && $stable(border)))
        else $error("window changed before it was taken");

endmodule

bind nms_top nms_assert nms_assert_i (
    .clock        (clock),
    .reset        (reset),
    .in_wr_en     (in_wr_en),
    .fifo_empty   (fifo_empty),
    .res_wr_en    (res_wr_en),
    .out_empty    (out_empty),
    .p_c          (p_c),
    .border       (border),
    .window_valid (window_valid),
    .window_take  (window_take)
);

//--- include/nms_model.svh
// Reference model computing the expected suppressed frame from an input frame
`ifndef NMS_MODEL_SVH
`define NMS_MODEL_SVH

function automatic void nms_model(
    input  nms_pkg::pixel_t frame_in  [nms_pkg::PIXEL_COUNT],
    output nms_pkg::pixel_t frame_out [nms_pkg::PIXEL_COUNT]
);
    int w;
    int idx;
    nms_pkg::pixel_t nw, n, ne, wp, c, e, sw, s, se;
    nms_pkg::grad_sum_t ns_sum, we_sum, nwse_sum, nesw_sum;

    w = nms_pkg::IMG_WIDTH;
    for (int r = 0; r < nms_pkg::IMG_HEIGHT; r++) begin
        for (int col = 0; col < nms_pkg::IMG_WIDTH; col++) begin
            idx = r * w + col;
            frame_out[idx] = '0;
            // Border positions always give zero
            if (r == 0 || r == nms_pkg::IMG_HEIGHT - 1 || col == 0 || col == w - 1) begin
                continue;
            end
            nw = frame_in[idx - w - 1];
            n  = frame_in[idx - w];
            ne = frame_in[idx - w + 1];
            wp = frame_in[idx - 1];
            c  = frame_in[idx];
            e  = frame_in[idx + 1];
            sw = frame_in[idx + w - 1];
            s  = frame_in[idx + w];
            se = frame_in[idx + w + 1];
            ns_sum = nms_pkg::grad_sum_t'(n) + nms_pkg::grad_sum_t'(s);
            we_sum = nms_pkg::grad_sum_t'(wp) + nms_pkg::grad_sum_t'(e);
            nwse_sum = nms_pkg::grad_sum_t'(nw) + nms_pkg::grad_sum_t'(se);
            nesw_sum = nms_pkg::grad_sum_t'(ne) + nms_pkg::grad_sum_t'(sw);
            if (ns_sum >= we_sum && ns_sum >= nwse_sum && ns_sum >= nesw_sum) begin
                frame_out[idx] = (c > wp && c >= e) ? c : '0;
            end else if (we_sum >= nwse_sum && we_sum >= nesw_sum) begin
                frame_out[idx] = (c > n && c >= s) ? c : '0;
            end else if (nwse_sum >= nesw_sum) begin
                frame_out[idx] = (c > ne && c >= sw) ? c : '0;
            end else begin
                frame_out[idx] = (c > nw && c >= se) ? c : '0;
            end
        end
    end
endfunction

`endif

//--- verification/nms_tb.sv
// Testbench for the NMS stage with stimulus, output compare, watchdog and reports
`timescale 1ns/1ns

module nms_tb;

    import nms_pkg::*;

    `include "nms_model.svh"

    // Seven frames in all, at most 20 cycles of 10 ns per pixel
    localparam int FRAME_TOTAL = 7;
    localparam time TIME_LIMIT = FRAME_TOTAL * PIXEL_COUNT * 20 * 10 + 5000;

    logic   clock;
    logic   reset;
    logic   in_wr_en;
    pixel_t in_din;
    logic   in_full;
    logic   out_rd_en;
    pixel_t out_dout;
    logic   out_empty;

    logic   hold_reader;
    integer seed;
    int     errors;
    int     tests_passed;
    int     tests_failed;
    int     out_index;
    pixel_t send_q [$];
    pixel_t expect_q [$];
    pixel_t frame [PIXEL_COUNT];
    pixel_t expect_frame [PIXEL_COUNT];

    nms_top nms_top_i (
        .clock     (clock),
        .reset     (reset),
        .in_wr_en  (in_wr_en),
        .in_din    (in_din),
        .in_full   (in_full),
        .out_rd_en (out_rd_en),
        .out_dout  (out_dout),
        .out_empty (out_empty)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #5 clock = ~clock;
        end
    end

    task automatic check_value(input int got, input int expected, input string what);
        if (got !== expected) begin
            $display("FAIL at %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
            errors++;
        end
    endtask

    // Hand a frame to the writer and its model result to the compare process
    task automatic queue_frame();
        nms_model(frame, expect_frame);
        for (int i = 0; i < PIXEL_COUNT; i++) begin
            send_q.push_back(frame[i]);
            expect_q.push_back(expect_frame[i]);
        end
    endtask

    task automatic fill_random();
        for (int i = 0; i < PIXEL_COUNT; i++) begin
            frame[i] = pixel_t'($random(seed));
        end
    endtask

    task automatic wait_frames_done();
        while (expect_q.size() != 0) begin
            @(posedge clock);
        end
        // A few idle cycles expose any extra output
        repeat (4) @(posedge clock);
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            tests_passed++;
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d mismatches", name, errors - errors_before);
        end
    endtask

    // Writer pushes whenever the input FIFO has room
    initial begin
        in_wr_en = 1'b0;
        in_din = '0;
        forever begin
            @(posedge clock);
            #1;
            if (!reset && send_q.size() != 0 && !in_full) begin
                in_wr_en = 1'b1;
                in_din = send_q.pop_front();
            end else begin
                in_wr_en = 1'b0;
            end
        end
    end

    // Reader pops whenever a result waits, unless held off
    initial begin
        out_rd_en = 1'b0;
        forever begin
            @(posedge clock);
            #1 out_rd_en = !reset && !hold_reader && !out_empty;
        end
    end

    // Popped words are stable between edges
    always @(negedge clock) begin
        if (!reset && out_rd_en && !out_empty) begin
            if (expect_q.size() == 0) begin
                $display("Error: unexpected extra output from the DUT at %0t ns", $time);
                errors++;
            end else begin
                check_value(int'(out_dout), int'(expect_q.pop_front()),
                            $sformatf("pixel %0d", out_index));
                out_index = (out_index + 1) % PIXEL_COUNT;
            end
        end
    end

    initial begin
        #(TIME_LIMIT);
        $display("Timeout: the tests did not finish within %0t ns", TIME_LIMIT);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        int mark;
        seed = 32'he2ce;
        errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        out_index = 0;
        hold_reader = 1'b0;
        reset = 1'b1;
        repeat (8) @(posedge clock);
        #1 reset = 1'b0;

        mark = errors;
        check_value(int'(out_empty), 1, "out_empty after reset");
        check_value(int'(in_full), 0, "in_full after reset");
        report_test("reset state", mark);

        mark = errors;
        fill_random();
        queue_frame();
        wait_frames_done();
        report_test("random frame", mark);

        mark = errors;
        foreach (frame[i]) frame[i] = 8'd77;
        queue_frame();
        wait_frames_done();
        report_test("flat frame", mark);

        // Two inner peaks and two on the border
        mark = errors;
        foreach (frame[i]) frame[i] = '0;
        frame[3 * IMG_WIDTH + 4] = 8'd200;
        frame[7 * IMG_WIDTH + 10] = 8'd150;
        frame[5 * IMG_WIDTH] = 8'd250;
        frame[9] = 8'd99;
        queue_frame();
        wait_frames_done();
        report_test("isolated peaks", mark);

        mark = errors;
        repeat (3) begin
            fill_random();
            queue_frame();
        end
        wait_frames_done();
        report_test("back-to-back frames", mark);

        mark = errors;
        @(negedge clock);
        hold_reader = 1'b1;
        fill_random();
        queue_frame();
        while (!in_full) begin
            @(posedge clock);
        end
        @(negedge clock);
        hold_reader = 1'b0;
        wait_frames_done();
        report_test("back-pressure", mark);

        $display("Tests passed %0d, failed %0d, mismatches %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+include
src/nms_pkg.sv
src/pixel_fifo.sv
src/line_window.sv
src/nms_suppress.sv
src/nms_top.sv
verification/nms_assert.sv
verification/nms_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = nms_tb
FLIST = flist.f
BUILD = obj_dir
PASS_MSG = *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)

run: build
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q -F "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD)
